// File: Makefile
VERILATOR := verilator
TOP       := tb_debugger_top
FILELIST  := verilog.f
VFLAGS    := --binary --timing -Wno-fatal
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "result: PASS ($(LOG))"; \
	else \
	  echo "result: FAIL ($(LOG))"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: src/dbg_cmd_pkg.sv
`include "dbg_defs.svh"

package dbg_cmd_pkg;

  // one byte plus its one-cycle strobe, used for rx and tx bytes
  typedef struct packed {
    logic                   valid;
    logic [`DBG_DATA_W-1:0] data;
  } byte_strobe_t;

  // first byte of every frame
  typedef enum logic [7:0] {
    OP_NOP   = 8'h00,
    OP_READ  = 8'h01,
    OP_WRITE = 8'h02
  } dbg_opcode_e;

  typedef enum logic [2:0] {
    ST_OPCODE  = 3'd0,
    ST_ADDR_HI = 3'd1,
    ST_ADDR_LO = 3'd2,
    ST_CNT_HI  = 3'd3,
    ST_CNT_LO  = 3'd4,
    ST_READ    = 3'd5,
    ST_WRITE   = 3'd6,
    ST_IGNORE  = 3'd7 // unknown opcode, wait for cs high
  } engine_state_e;

endpackage

// File: src/dbg_defs.svh
`ifndef DBG_DEFS_SVH
`define DBG_DEFS_SVH

// memory address width, one 6502 address space
`define DBG_ADDR_W 16

// byte width on the SPI link and in the RAM
`define DBG_DATA_W 8

// number of RAM words, full 64 KiB
`define DBG_RAM_DEPTH 65536

// flip-flops on each SPI input before edge detection
`define DBG_SYNC_STAGES 2

`endif

// File: src/dbg_mem_pkg.sv
`include "dbg_defs.svh"

package dbg_mem_pkg;

  // single-port RAM request, en qualifies both read and write
  typedef struct packed {
    logic                   en;
    logic                   we;    // 1 = write, 0 = read
    logic [`DBG_ADDR_W-1:0] addr;
    logic [`DBG_DATA_W-1:0] wdata;
  } mem_req_t;

endpackage

// File: src/debug_cmd_engine.sv
`include "dbg_defs.svh"

module debug_cmd_engine (
  input  logic                      i_clk,
  input  logic                      i_rst,

  input  dbg_cmd_pkg::byte_strobe_t i_rx,
  input  logic                      i_frame_end,  // cs went high, abort any command
  output dbg_cmd_pkg::byte_strobe_t o_tx,

  output dbg_mem_pkg::mem_req_t     o_mem_req,
  input  logic [`DBG_DATA_W-1:0]    i_mem_rdata   // valid one cycle after a read
);

  localparam int ADDR_W = `DBG_ADDR_W;
  localparam int DATA_W = `DBG_DATA_W;
  localparam int CNT_W = 2 * DATA_W; // count arrives as two bytes

  dbg_cmd_pkg::engine_state_e r_state;
  dbg_cmd_pkg::dbg_opcode_e   r_opcode;
  dbg_cmd_pkg::dbg_opcode_e   w_rx_opcode;

  logic [ADDR_W-1:0]          r_addr;     // next address to access
  logic [CNT_W-1:0]           r_count;
  logic [CNT_W-1:0]           w_count_full;

  dbg_mem_pkg::mem_req_t      r_req;
  logic                       r_rd_pending;

  assign w_rx_opcode  = dbg_cmd_pkg::dbg_opcode_e'(i_rx.data);
  assign w_count_full = {r_count[CNT_W-1:DATA_W], i_rx.data};

  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      r_state      <= dbg_cmd_pkg::ST_OPCODE;
      r_req.en     <= 1'b0;
      r_req.we     <= 1'b0;
      r_rd_pending <= 1'b0;
    end
    else
    begin
      r_rd_pending <= r_req.en & ~r_req.we; // data is on i_mem_rdata next cycle
      r_req.en     <= 1'b0;
      r_req.we     <= 1'b0;

      if (i_frame_end)
        r_state <= dbg_cmd_pkg::ST_OPCODE;
      else if (i_rx.valid)
      begin
        case (r_state)
          dbg_cmd_pkg::ST_OPCODE:
          begin
            case (w_rx_opcode)
              dbg_cmd_pkg::OP_NOP: ; // stay here
              dbg_cmd_pkg::OP_READ,
              dbg_cmd_pkg::OP_WRITE:
              begin
                r_opcode <= w_rx_opcode;
                r_state  <= dbg_cmd_pkg::ST_ADDR_HI;
              end
              default:
                r_state <= dbg_cmd_pkg::ST_IGNORE;
            endcase
          end

          dbg_cmd_pkg::ST_ADDR_HI:
          begin
            r_addr[ADDR_W-1:DATA_W] <= i_rx.data;
            r_state                 <= dbg_cmd_pkg::ST_ADDR_LO;
          end

          dbg_cmd_pkg::ST_ADDR_LO:
          begin
            r_addr[DATA_W-1:0] <= i_rx.data;
            r_state            <= dbg_cmd_pkg::ST_CNT_HI;
          end

          dbg_cmd_pkg::ST_CNT_HI:
          begin
            r_count[CNT_W-1:DATA_W] <= i_rx.data;
            r_state                 <= dbg_cmd_pkg::ST_CNT_LO;
          end

          dbg_cmd_pkg::ST_CNT_LO:
          begin
            if (w_count_full == '0)
              r_state <= dbg_cmd_pkg::ST_OPCODE; // empty command
            else if (r_opcode == dbg_cmd_pkg::OP_READ)
            begin
              // prefetch the first byte so it goes out in the next slot
              r_req.en   <= 1'b1;
              r_req.addr <= r_addr;
              r_addr     <= r_addr + 1'b1;
              r_count    <= w_count_full - 1'b1; // reads still to issue
              r_state    <= dbg_cmd_pkg::ST_READ;
            end
            else
            begin
              r_count <= w_count_full;
              r_state <= dbg_cmd_pkg::ST_WRITE;
            end
          end

          dbg_cmd_pkg::ST_READ:
          begin
            if (r_count == '0)
              r_state <= dbg_cmd_pkg::ST_OPCODE; // last reply byte just went out
            else
            begin
              r_req.en   <= 1'b1;
              r_req.addr <= r_addr;
              r_addr     <= r_addr + 1'b1; // wraps at top of memory
              r_count    <= r_count - 1'b1;
            end
          end

          dbg_cmd_pkg::ST_WRITE:
          begin
            r_req.en    <= 1'b1;
            r_req.we    <= 1'b1;
            r_req.addr  <= r_addr;
            r_req.wdata <= i_rx.data;
            r_addr      <= r_addr + 1'b1;
            r_count     <= r_count - 1'b1;
            if (r_count == CNT_W'(1))
              r_state <= dbg_cmd_pkg::ST_OPCODE;
          end

          dbg_cmd_pkg::ST_IGNORE: ; // bytes dropped until frame end
        endcase
      end
    end
  end

  assign o_mem_req = r_req;

  // read data goes straight to the transmitter
  assign o_tx = '{valid: r_rd_pending, data: i_mem_rdata};

endmodule

// File: src/debug_ram.sv
`include "dbg_defs.svh"

module debug_ram (
  input  logic                   i_clk,
  input  dbg_mem_pkg::mem_req_t  i_req,
  output logic [`DBG_DATA_W-1:0] o_rdata
);

  logic [`DBG_DATA_W-1:0] r_mem [`DBG_RAM_DEPTH];

  // memory starts cleared in simulation
  initial
  begin
    for (int i = 0; i < `DBG_RAM_DEPTH; i++)
      r_mem[i] = '0;
  end

  // read-first, data out one cycle after the request
  always_ff @(posedge i_clk)
  begin
    if (i_req.en)
    begin
      if (i_req.we)
        r_mem[i_req.addr] <= i_req.wdata;
      o_rdata <= r_mem[i_req.addr]; // old contents on a write
    end
  end

endmodule

// File: src/debugger_top.sv
`include "dbg_defs.svh"

module debugger_top (
  input  logic i_clk,
  input  logic i_rst,

  input  logic i_spi_cs_n,
  input  logic i_spi_clk,
  input  logic i_spi_copi,
  output logic o_spi_cipo  // board wrapper adds high-z when cs is high
);

  dbg_cmd_pkg::byte_strobe_t w_rx;
  dbg_cmd_pkg::byte_strobe_t w_tx;
  logic                      w_frame_end;

  dbg_mem_pkg::mem_req_t     w_mem_req;
  logic [`DBG_DATA_W-1:0]    w_mem_rdata;

  spi_peripheral u_spi (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_spi_cs_n  (i_spi_cs_n),
    .i_spi_clk   (i_spi_clk),
    .i_spi_copi  (i_spi_copi),
    .o_spi_cipo  (o_spi_cipo),
    .i_tx        (w_tx),
    .o_rx        (w_rx),
    .o_frame_end (w_frame_end)
  );

  debug_cmd_engine u_engine (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_rx        (w_rx),
    .i_frame_end (w_frame_end),
    .o_tx        (w_tx),
    .o_mem_req   (w_mem_req),
    .i_mem_rdata (w_mem_rdata)
  );

  debug_ram u_ram (
    .i_clk   (i_clk),
    .i_req   (w_mem_req),
    .o_rdata (w_mem_rdata)
  );

endmodule

// File: src/spi_peripheral.sv
`include "dbg_defs.svh"

module spi_peripheral (
  input  logic                      i_clk,
  input  logic                      i_rst,

  input  logic                      i_spi_cs_n,
  input  logic                      i_spi_clk,  // SPI clock from controller, mode 0
  input  logic                      i_spi_copi,
  output logic                      o_spi_cipo, // low while cs is high

  input  dbg_cmd_pkg::byte_strobe_t i_tx,       // byte for the next SPI byte slot
  output dbg_cmd_pkg::byte_strobe_t o_rx,
  output logic                      o_frame_end
);

  localparam int SYNC_N = `DBG_SYNC_STAGES;
  localparam int DATA_W = `DBG_DATA_W;
  localparam int CNT_W = $clog2(DATA_W);
  localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(DATA_W - 1);

  logic [SYNC_N-1:0]         r_sck_sync;
  logic [SYNC_N-1:0]         r_cs_n_sync;
  logic [SYNC_N-1:0]         r_copi_sync;
  logic                      r_sck_prev;
  logic                      r_cs_n_prev;

  logic                      w_sck;
  logic                      w_cs_n;
  logic                      w_copi;
  logic                      w_sck_rise;
  logic                      w_sck_fall;
  logic                      w_cs_rise;

  logic [CNT_W-1:0]          r_rx_cnt;
  logic [DATA_W-1:0]         r_rx_shift;
  logic                      r_rx_valid;

  logic [CNT_W-1:0]          r_tx_cnt;
  logic [DATA_W-1:0]         r_tx_shift;
  dbg_cmd_pkg::byte_strobe_t r_tx_hold;    // byte waiting for the next slot

  logic                      r_frame_end;

  // input synchronizers, idle values on reset
  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      r_sck_sync  <= '0;
      r_cs_n_sync <= '1;
      r_copi_sync <= '0;
      r_sck_prev  <= 1'b0;
      r_cs_n_prev <= 1'b1;
    end
    else
    begin
      r_sck_sync  <= {r_sck_sync[SYNC_N-2:0], i_spi_clk};
      r_cs_n_sync <= {r_cs_n_sync[SYNC_N-2:0], i_spi_cs_n};
      r_copi_sync <= {r_copi_sync[SYNC_N-2:0], i_spi_copi};
      r_sck_prev  <= w_sck;
      r_cs_n_prev <= w_cs_n;
    end
  end

  assign w_sck  = r_sck_sync[SYNC_N-1];
  assign w_cs_n = r_cs_n_sync[SYNC_N-1];
  assign w_copi = r_copi_sync[SYNC_N-1];

  assign w_sck_rise = w_sck & ~r_sck_prev & ~w_cs_n;
  assign w_sck_fall = ~w_sck & r_sck_prev & ~w_cs_n;
  assign w_cs_rise  = w_cs_n & ~r_cs_n_prev;

  // receive on rising SCK, MSB first
  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      r_rx_cnt   <= '0;
      r_rx_valid <= 1'b0;
    end
    else
    begin
      r_rx_valid <= 1'b0;
      if (w_cs_n)
        r_rx_cnt <= '0;
      else if (w_sck_rise)
      begin
        r_rx_cnt <= r_rx_cnt + 1'b1;
        if (r_rx_cnt == LAST_BIT)
          r_rx_valid <= 1'b1; // 8th bit just sampled
      end
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (w_sck_rise)
      r_rx_shift <= {r_rx_shift[DATA_W-2:0], w_copi};
  end

  assign o_rx = '{valid: r_rx_valid, data: r_rx_shift};

  // transmit on falling SCK; a new byte is loaded on the 8th falling edge
  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      r_tx_cnt        <= '0;
      r_tx_shift      <= '0;
      r_tx_hold.valid <= 1'b0;
    end
    else
    begin
      if (i_tx.valid)
      begin
        r_tx_hold.valid <= 1'b1;
        r_tx_hold.data  <= i_tx.data;
      end
      if (w_cs_n)
      begin
        r_tx_cnt        <= '0;
        r_tx_shift      <= '0;
        r_tx_hold.valid <= 1'b0;
      end
      else if (w_sck_fall)
      begin
        r_tx_cnt <= r_tx_cnt + 1'b1;
        if (r_tx_cnt == LAST_BIT)
        begin
          r_tx_hold.valid <= 1'b0; // one-shot, unloaded slots send zero
          if (i_tx.valid)
            r_tx_shift <= i_tx.data;
          else if (r_tx_hold.valid)
            r_tx_shift <= r_tx_hold.data;
          else
            r_tx_shift <= '0;
        end
        else
          r_tx_shift <= {r_tx_shift[DATA_W-2:0], 1'b0};
      end
    end
  end

  assign o_spi_cipo = r_tx_shift[DATA_W-1];

  always_ff @(posedge i_clk)
  begin
    if (i_rst)
      r_frame_end <= 1'b0;
    else
      r_frame_end <= w_cs_rise;
  end

  assign o_frame_end = r_frame_end;

endmodule

// File: verif/debugger_tests.txt
// one frame per line in hex: bytes sent, partial bits after them, the sent bytes,
// then the number of read reply bytes and those bytes; a line of 00 ends the list
09 00 02 12 34 00 04 de ad be ef 00
09 00 01 12 34 00 04 ff ff ff ff 04 de ad be ef
// wrap from ffff to 0000
09 00 02 ff fe 00 04 a1 a2 a3 a4 00
0b 00 01 ff fd 00 06 00 00 00 00 00 00 06 00 a1 a2 a3 a4 00
// write cut short inside a byte, then a fresh read
08 05 02 20 00 00 08 11 22 33 00
0a 00 01 20 00 00 05 00 00 00 00 00 05 11 22 33 00 00
07 03 01 12 34 00 0a 00 00 02 de ad
06 00 02 12 38 00 01 5a 00
0a 00 01 12 34 00 05 00 00 00 00 00 05 de ad be ef 5a
// unknown opcode, nop and zero counts write nothing
07 00 7e 30 00 00 02 99 99 00
06 00 00 00 00 ff 02 30 00
01 04 00 00
07 00 01 30 00 00 00 00 00 00
06 00 02 30 00 00 00 00 00
09 00 01 30 00 00 04 00 00 00 00 04 00 00 00 00
// two commands in one frame, burst and never-written reads
0c 00 02 40 00 00 01 77 01 40 00 00 01 00 01 77
0d 00 02 50 00 00 08 01 23 45 67 89 ab cd ef 00
0f 00 01 4f ff 00 0a 00 00 00 00 00 00 00 00 00 00 0a 00 01 23 45 67 89 ab cd ef 00
08 00 01 80 00 00 03 00 00 00 03 00 00 00
00

// File: verif/tb_clock_gen.sv
module tb_clock_gen (
  output logic o_clk,
  output logic o_rst
);

  localparam int HALF_CYCLE = 2;    // period of 4
  localparam int RESET_CYCLES = 16;

  initial
  begin
    o_clk = 1'b0;
    forever #HALF_CYCLE o_clk = ~o_clk;
  end

  initial
  begin
    o_rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_rst <= 1'b0;   // released on a rising edge
  end

endmodule

// File: verif/tb_debugger_top.sv
`include "dbg_defs.svh"

module tb_debugger_top;

  localparam int ADDR_W = `DBG_ADDR_W;
  localparam int DATA_W = `DBG_DATA_W;
  localparam int HALF_PERIOD = 8;   // i_clk cycles per SCK phase
  localparam int STIM_WORDS = 1024;
  localparam int MAX_FRAMES = 64;
  localparam int WAIT_LIMIT = 200;  // cycles allowed for any wait loop

  // phases of the reference model of the command protocol
  localparam int PH_OPCODE = 0;
  localparam int PH_ADDR_HI = 1;
  localparam int PH_ADDR_LO = 2;
  localparam int PH_CNT_HI = 3;
  localparam int PH_CNT_LO = 4;
  localparam int PH_READ = 5;
  localparam int PH_WRITE = 6;
  localparam int PH_IGNORE = 7;

  logic              clk;
  logic              rst;
  logic              spi_cs_n;
  logic              spi_clk;
  logic              spi_copi;
  logic              spi_cipo;

  logic [DATA_W-1:0] stim [STIM_WORDS];
  logic [DATA_W-1:0] model_mem [`DBG_RAM_DEPTH];
  logic [16:0]       lfsr;
  int                m_phase;
  logic              m_read;
  logic [ADDR_W-1:0] m_addr;
  logic [ADDR_W-1:0] m_left;     // count is 16 bits like the address
  int                checks;
  int                errors;
  int                failures;   // timeouts and a missing test file

  tb_clock_gen u_clock_gen (
    .o_clk (clk),
    .o_rst (rst)
  );

  debugger_top dut (
    .i_clk      (clk),
    .i_rst      (rst),
    .i_spi_cs_n (spi_cs_n),
    .i_spi_clk  (spi_clk),
    .i_spi_copi (spi_copi),
    .o_spi_cipo (spi_cipo)
  );

  // galois form with polynomial x^17 + x^14 + 1
  function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    if (s[0])
      return (s >> 1) ^ 17'h12000;
    else
      return s >> 1;
  endfunction

  task automatic take_random(input int n_bits, output int value);
    value = 0;
    for (int i = 0; i < n_bits; i++)
    begin
      value = (value << 1) | int'(lfsr[0]);
      lfsr = lfsr_next(lfsr);   // one step per bit
    end
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Error at %0t: %s, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic report_and_finish();
    $display("checks %0d, errors %0d, other failures %0d", checks, errors, failures);
    if (errors == 0 && failures == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (rst !== 1'b0 && n < WAIT_LIMIT)
    begin
      @(posedge clk);
      n++;
    end
    if (rst !== 1'b0)
    begin
      $display("reset was still asserted after %0d cycles", WAIT_LIMIT);
      failures++;
    end
  endtask

  task automatic wait_cipo_low();
    int n;
    n = 0;
    while (spi_cipo !== 1'b0 && n < WAIT_LIMIT)
    begin
      @(posedge clk);
      n++;
    end
    if (spi_cipo !== 1'b0)
    begin
      $display("CIPO was not driven low after chip select went high");
      failures++;
    end
  endtask

  // mode 0 transfer of the top n_bits of a byte with CIPO sampled before each rising SCK
  task automatic spi_xfer(input logic [DATA_W-1:0] tx, input int n_bits,
                          output logic [DATA_W-1:0] rx);
    rx = '0;
    for (int i = DATA_W - 1; i >= DATA_W - n_bits; i--)
    begin
      spi_copi <= tx[i];
      repeat (HALF_PERIOD) @(posedge clk);
      rx[i] = spi_cipo;
      spi_clk <= 1'b1;
      repeat (HALF_PERIOD) @(posedge clk);
      spi_clk <= 1'b0;
    end
  endtask

  // advance the reference model by one received byte
  task automatic model_byte(input logic [DATA_W-1:0] b);
    case (m_phase)
      PH_OPCODE:
      begin
        if (b == dbg_cmd_pkg::OP_READ || b == dbg_cmd_pkg::OP_WRITE)
        begin
          m_read  = (b == dbg_cmd_pkg::OP_READ);
          m_phase = PH_ADDR_HI;
        end
        else if (b != dbg_cmd_pkg::OP_NOP)
          m_phase = PH_IGNORE;
      end
      PH_ADDR_HI:
      begin
        m_addr[ADDR_W-1:DATA_W] = b;
        m_phase = PH_ADDR_LO;
      end
      PH_ADDR_LO:
      begin
        m_addr[DATA_W-1:0] = b;
        m_phase = PH_CNT_HI;
      end
      PH_CNT_HI:
      begin
        m_left[ADDR_W-1:DATA_W] = b;
        m_phase = PH_CNT_LO;
      end
      PH_CNT_LO:
      begin
        m_left[DATA_W-1:0] = b;
        if (m_left == '0)
          m_phase = PH_OPCODE;
        else if (m_read)
          m_phase = PH_READ;
        else
          m_phase = PH_WRITE;
      end
      PH_READ, PH_WRITE:
      begin
        if (m_phase == PH_WRITE)
          model_mem[m_addr] = b;
        m_addr = m_addr + 1'b1;   // wraps past ffff
        m_left = m_left - 1'b1;
        if (m_left == '0)
          m_phase = PH_OPCODE;
      end
      default: ;
    endcase
  endtask

  // one frame as described by one line of the test file
  task automatic run_frame(inout int pos);
    int                n_bytes;
    int                n_part;
    int                n_exp;
    int                exp_at;
    int                n_reads;
    int                gap;
    int                rnd;
    logic [DATA_W-1:0] tx_byte;
    logic [DATA_W-1:0] rx_byte;
    logic [DATA_W-1:0] exp_byte;
    n_bytes = int'(stim[pos]);
    n_part  = int'(stim[pos + 1]);
    n_exp   = int'(stim[pos + 2 + n_bytes]);
    exp_at  = pos + 3 + n_bytes;
    n_reads = 0;
    m_phase = PH_OPCODE;
    @(posedge clk);
    spi_cs_n <= 1'b0;
    for (int k = 0; k < n_bytes; k++)
    begin
      tx_byte  = stim[pos + 2 + k];
      exp_byte = (m_phase == PH_READ) ? model_mem[m_addr] : '0;
      take_random(4, gap);
      repeat (gap) @(posedge clk);
      spi_xfer(tx_byte, DATA_W, rx_byte);
      check_value(32'(rx_byte), 32'(exp_byte), "reply byte vs memory model");
      if (m_phase == PH_READ)
      begin
        if (n_reads < n_exp)
          check_value(32'(rx_byte), 32'(stim[exp_at + n_reads]), "read byte vs test file");
        n_reads++;
      end
      model_byte(tx_byte);
    end
    if (n_part > 0)
    begin
      take_random(n_part, rnd);   // bits of the aborted byte
      tx_byte = DATA_W'(rnd << (DATA_W - n_part));
      spi_xfer(tx_byte, n_part, rx_byte);
    end
    repeat (HALF_PERIOD) @(posedge clk);
    spi_cs_n <= 1'b1;
    repeat (HALF_PERIOD) @(posedge clk);
    wait_cipo_low();
    check_value(n_reads, n_exp, "read bytes in frame");
    take_random(4, gap);
    repeat (gap) @(posedge clk);
    pos = exp_at + n_exp;
  endtask

  initial
  begin
    int pos;
    int frames;
    spi_cs_n = 1'b1;
    spi_clk  = 1'b0;
    spi_copi = 1'b0;
    lfsr     = 17'd71075;
    m_phase  = PH_OPCODE;
    m_read   = 1'b0;
    m_addr   = '0;
    m_left   = '0;
    checks   = 0;
    errors   = 0;
    failures = 0;
    for (int i = 0; i < `DBG_RAM_DEPTH; i++)
      model_mem[i] = '0;   // RAM starts cleared
    $readmemh("verif/debugger_tests.txt", stim);
    wait_reset_release();
    pos    = 0;
    frames = 0;
    while (failures == 0 && stim[pos] != '0 && frames < MAX_FRAMES)
    begin
      run_frame(pos);
      frames++;
    end
    if (frames == 0 && failures == 0)
    begin
      $display("no frames were read from the test file");
      failures++;
    end
    report_and_finish();
  end

endmodule

// File: verilog.f
+incdir+src
src/dbg_cmd_pkg.sv
src/dbg_mem_pkg.sv
src/spi_peripheral.sv
src/debug_ram.sv
src/debug_cmd_engine.sv
src/debugger_top.sv
verif/tb_clock_gen.sv
verif/tb_debugger_top.sv
